//--- project.f
+incdir+common
common/core_pkg.sv
fetch/fetch_unit.sv
execute/exec_unit.sv
src/reg_file.sv
src/mem_arbiter.sv
src/addr_xbar.sv
src/timer_clint.sv
src/core_top.sv
tests/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module core_tb -o core_tb_sim

out="$(./obj_dir/core_tb_sim)"
printf '%s\n' "$out"

grep -q "Finished with no errors" <<< "$out"

//--- tests/core_tb.sv
`timescale 1ns/1ps
`include "core_consts.svh"
`default_nettype none

module core_tb;
  import core_pkg::*;

  localparam int PROG_WORDS    = 28;
  localparam int MAX_STORES    = 32;
  localparam int STORE_TIMEOUT = 20000;

  logic  clock       = 1'b0;
  logic  rst_n       = 1'b0;
  logic  mem_arvalid;
  addr_t mem_araddr;
  logic  mem_arready = 1'b0;
  logic  mem_rvalid  = 1'b0;
  word_t mem_rdata   = '0;
  logic  mem_awvalid;
  addr_t mem_awaddr;
  word_t mem_wdata;
  logic  mem_awready = 1'b0;
  logic  mem_bvalid  = 1'b0;

  word_t mem [1024];
  word_t ref_mem [1024];
  logic  visited [PROG_WORDS];
  logic  fetchable [PROG_WORDS];
  addr_t exp_addr [MAX_STORES];
  word_t exp_data [MAX_STORES];
  logic  exp_tmr [MAX_STORES];
  int    exp_count     = 0;
  int    store_count   = 0;
  logic  tmr_seen      = 1'b0;
  word_t tmr_last      = '0;
  logic  first_ar_done = 1'b0;
  int    errors        = 0;
  word_t rng           = 32'd20586;
  logic  rd_busy       = 1'b0;
  int    rd_delay      = 0;
  addr_t rd_addr_q     = '0;
  logic  wr_busy       = 1'b0;
  int    wr_delay      = 0;

  core_top dut0 (
    .clock(clock), .rst_n(rst_n),
    .mem_arvalid(mem_arvalid), .mem_araddr(mem_araddr), .mem_arready(mem_arready),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .mem_awvalid(mem_awvalid), .mem_awaddr(mem_awaddr), .mem_wdata(mem_wdata),
    .mem_awready(mem_awready), .mem_bvalid(mem_bvalid)
  );

  initial begin
    forever #10 clock = ~clock;
  end

  function automatic word_t xorshift(word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t itype_word(opcode_t op, int rd, int f3, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t rtype_word(int rd, int rs1, int rs2, int f7);
    return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OP};
  endfunction

  function automatic word_t stype_word(int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], STORE};
  endfunction

  function automatic word_t btype_word(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], BRANCH};
  endfunction

  function automatic word_t utype_word(int rd, int imm);
    return {imm[19:0], rd[4:0], LUI};
  endfunction

  function automatic word_t jtype_word(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
  endfunction

  task automatic report_fail(string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // the program skips words 9..10, 13 and 25, and reads the timer twice
  task automatic build_image();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = word_t'(i * 4) ^ 32'hA5C3_0000;
    end
    mem[0]  = itype_word(OP_IMM, 1, 0, 0, 'h123);
    mem[1]  = utype_word(2, 'h12345);
    mem[2]  = rtype_word(3, 1, 2, 'h00);
    mem[3]  = stype_word(0, 3, 'h200);
    mem[4]  = itype_word(LOAD, 4, 2, 0, 'h240);
    mem[5]  = rtype_word(5, 4, 1, 'h20);
    mem[6]  = stype_word(0, 5, 'h204);
    mem[7]  = btype_word(0, 1, 1, 16);
    mem[8]  = stype_word(0, 1, 'h208);
    mem[9]  = stype_word(0, 2, 'h20c);
    mem[10] = stype_word(0, 3, 'h210);
    mem[11] = btype_word(1, 1, 0, 12);
    mem[12] = stype_word(0, 4, 'h214);
    mem[13] = stype_word(0, 5, 'h218);
    mem[14] = btype_word(0, 1, 0, 8);
    mem[15] = stype_word(0, 1, 'h21c);
    mem[16] = itype_word(LOAD, 6, 2, 0, 'h204);
    mem[17] = stype_word(0, 6, 'h220);
    mem[18] = utype_word(7, `CORE_TIMER_BASE >> 12);
    mem[19] = itype_word(LOAD, 8, 2, 7, 0);
    mem[20] = itype_word(LOAD, 9, 2, 7, 0);
    mem[21] = stype_word(0, 8, 'h224);
    mem[22] = stype_word(0, 9, 'h228);
    mem[23] = jtype_word(10, 12);
    mem[24] = stype_word(0, 1, 'h22c);
    mem[25] = stype_word(0, 2, 'h230);
    mem[26] = stype_word(0, 10, 'h234);
    mem[27] = jtype_word(0, 0);
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = mem[i];
    end
  endtask

  // instruction-set model, a JAL to itself ends the program
  task automatic run_reference();
    word_t regs [32];
    logic  from_tmr [32];
    addr_t pc;
    addr_t next_pc;
    addr_t ea;
    word_t ins;
    word_t a;
    word_t b;
    word_t val;
    logic  wr;
    logic  tmr_load;
    logic  halted;
    int    steps;
    for (int i = 0; i < 32; i++) begin
      regs[i]     = '0;
      from_tmr[i] = 1'b0;
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      visited[i] = 1'b0;
    end
    pc     = `CORE_RESET_PC;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < 1000) begin
      ins = ref_mem[pc[11:2]];
      if ((pc >> 2) < PROG_WORDS) begin
        visited[int'(pc >> 2)] = 1'b1;
      end
      a        = regs[ins[19:15]];
      b        = regs[ins[24:20]];
      next_pc  = pc + 32'd4;
      wr       = 1'b0;
      tmr_load = 1'b0;
      val      = '0;
      case (opcode_t'(ins[6:0]))
        OP_IMM: begin
          wr  = (ins[14:12] == 3'b000);
          val = a + {{20{ins[31]}}, ins[31:20]};
        end
        OP: begin
          wr  = (ins[14:12] == 3'b000) && (ins[31:25] == 7'h00 || ins[31:25] == 7'h20);
          val = ins[30] ? a - b : a + b;
        end
        LUI: begin
          wr  = 1'b1;
          val = {ins[31:12], 12'h000};
        end
        LOAD: begin
          if (ins[14:12] == 3'b010) begin
            ea = a + {{20{ins[31]}}, ins[31:20]};
            wr = 1'b1;
            if ((ea & ~32'hF) == `CORE_TIMER_BASE) begin
              tmr_load = 1'b1;
            end else begin
              val = ref_mem[ea[11:2]];
            end
          end
        end
        STORE: begin
          if (ins[14:12] == 3'b010) begin
            ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            ref_mem[ea[11:2]]  = b;
            exp_addr[exp_count] = ea;
            exp_data[exp_count] = b;
            exp_tmr[exp_count]  = from_tmr[ins[24:20]];
            exp_count++;
          end
        end
        BRANCH: begin
          if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
            next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        JAL: begin
          wr      = 1'b1;
          val     = pc + 32'd4;
          next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
          halted  = (next_pc == pc);
        end
        default: begin
          wr = 1'b0;
        end
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        regs[ins[11:7]]     = val;
        from_tmr[ins[11:7]] = tmr_load;
      end
      pc = next_pc;
      steps++;
    end
    // fetch may prefetch only the word after an executed one
    for (int i = 0; i < PROG_WORDS; i++) begin
      fetchable[i] = visited[i] || (i > 0 && visited[i - 1]);
    end
  endtask

  function automatic logic may_fetch(addr_t addr);
    if (addr >= PROG_WORDS * 4) begin
      return 1'b1;
    end
    return fetchable[addr[11:2]];
  endfunction

  function automatic logic store_ok(int idx, addr_t addr, word_t data, logic seen, word_t last);
    if (idx >= exp_count || addr != exp_addr[idx]) begin
      return 1'b0;
    end
    if (!exp_tmr[idx]) begin
      return data == exp_data[idx];
    end
    return !seen || (data > last);
  endfunction

  // one random stream serves both channels so the run repeats exactly
  always @(posedge clock) begin
    if (!rst_n) begin
      mem_arready <= 1'b0;
      mem_rvalid  <= 1'b0;
      mem_awready <= 1'b0;
      mem_bvalid  <= 1'b0;
      rd_busy     <= 1'b0;
      wr_busy     <= 1'b0;
    end else begin
      mem_rvalid <= 1'b0;
      mem_bvalid <= 1'b0;
      rng = xorshift(rng);
      if (rd_busy) begin
        if (rd_delay == 0) begin
          mem_rvalid <= 1'b1;
          mem_rdata  <= mem[rd_addr_q[11:2]];
          rd_busy    <= 1'b0;
        end else begin
          rd_delay <= rd_delay - 1;
        end
      end
      if (mem_arvalid && mem_arready) begin
        mem_arready <= 1'b0;
        rd_busy     <= 1'b1;
        rd_addr_q   <= mem_araddr;
        rd_delay    <= int'(rng % 6);
      end else if (!rd_busy) begin
        mem_arready <= (rng[9:8] != 2'b00);
      end
      rng = xorshift(rng);
      if (wr_busy) begin
        if (wr_delay == 0) begin
          mem_bvalid <= 1'b1;
          wr_busy    <= 1'b0;
        end else begin
          wr_delay <= wr_delay - 1;
        end
      end
      if (mem_awvalid && mem_awready) begin
        mem[mem_awaddr[11:2]] = mem_wdata;
        mem_awready <= 1'b0;
        wr_busy     <= 1'b1;
        wr_delay    <= int'(rng % 6);
      end else if (!wr_busy) begin
        mem_awready <= (rng[9:8] != 2'b00);
      end
    end
  end

  always @(posedge clock) begin
    if (mem_arvalid) begin
      first_ar_done <= 1'b1;
    end
    if (mem_awvalid && mem_awready) begin
      if (store_count < exp_count && exp_tmr[store_count]) begin
        tmr_seen <= 1'b1;
        tmr_last <= mem_wdata;
      end
      store_count <= store_count + 1;
    end
  end

  a_quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !mem_arvalid && !mem_awvalid)
    else report_fail("request raised during reset");

  a_first_fetch: assert property (@(posedge clock) disable iff (!rst_n)
    (mem_arvalid && !first_ar_done) |-> (mem_araddr == `CORE_RESET_PC))
    else report_fail($sformatf("first fetch at %h", mem_araddr));

  a_store_matches: assert property (@(posedge clock) disable iff (!rst_n)
    (mem_awvalid && mem_awready) |->
      store_ok(store_count, mem_awaddr, mem_wdata, tmr_seen, tmr_last))
    else report_fail($sformatf("store %0d wrote %h to %h", store_count, mem_wdata, mem_awaddr));

  a_no_skipped_fetch: assert property (@(posedge clock) disable iff (!rst_n)
    mem_arvalid |-> may_fetch(mem_araddr))
    else report_fail($sformatf("read of skipped word at %h", mem_araddr));

  a_timer_local: assert property (@(posedge clock) disable iff (!rst_n)
    mem_arvalid |-> ((mem_araddr & ~32'hF) != `CORE_TIMER_BASE))
    else report_fail($sformatf("timer address %h reached memory", mem_araddr));

  a_ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (mem_arvalid && !mem_arready) |=> (mem_arvalid && $stable(mem_araddr)))
    else report_fail("read request changed before acceptance");

  a_aw_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (mem_awvalid && !mem_awready) |=>
      (mem_awvalid && $stable(mem_awaddr) && $stable(mem_wdata)))
    else report_fail("write request changed before acceptance");

  initial begin
    int waited;
    build_image();
    run_reference();
    repeat (10) @(posedge clock);
    rst_n <= 1'b1;
    waited = 0;
    while (store_count < exp_count && waited < STORE_TIMEOUT) begin
      @(posedge clock);
      waited++;
    end
    if (store_count < exp_count) begin
      errors++;
      $display("timed out with %0d of %0d stores seen", store_count, exp_count);
    end
    // the core now spins on its last jump, any later store is flagged
    waited = 0;
    while (waited < 200) begin
      @(posedge clock);
      waited++;
    end
    $display("errors: %0d, stores: %0d of %0d", errors, store_count, exp_count);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  wire                   clock,
  input  wire                   rst_n,
  output logic                  mem_arvalid,
  output core_pkg::addr_t       mem_araddr,
  input  wire                   mem_arready,
  input  wire                   mem_rvalid,
  input  wire  core_pkg::word_t mem_rdata,
  output logic                  mem_awvalid,
  output core_pkg::addr_t       mem_awaddr,
  output core_pkg::word_t       mem_wdata,
  input  wire                   mem_awready,
  input  wire                   mem_bvalid
);
  import core_pkg::*;

  logic     inst_valid, inst_ready, flush;
  addr_t    inst_pc, flush_pc;
  word_t    inst_word;
  reg_idx_t rs1_addr, rs2_addr, rd_addr;
  word_t    rs1_data, rs2_data, rd_data;
  logic     rd_we;
  logic     if_arvalid, if_arready, if_rvalid;
  addr_t    if_araddr;
  word_t    if_rdata;
  logic     ex_arvalid, ex_arready, ex_rvalid;
  addr_t    ex_araddr;
  word_t    ex_rdata;
  logic     bus_arvalid, bus_arready, bus_rvalid;
  addr_t    bus_araddr;
  word_t    bus_rdata;
  logic     tmr_rd;
  logic [1:0] tmr_addr;
  word_t    tmr_rdata;

  fetch_unit fetch0 (
    .clock(clock), .rst_n(rst_n),
    .flush(flush), .flush_pc(flush_pc),
    .ar_valid(if_arvalid), .ar_addr(if_araddr), .ar_ready(if_arready),
    .r_valid(if_rvalid), .r_data(if_rdata),
    .inst_valid(inst_valid), .inst_pc(inst_pc), .inst_word(inst_word),
    .inst_ready(inst_ready)
  );

  exec_unit exec0 (
    .clock(clock), .rst_n(rst_n),
    .inst_valid(inst_valid), .inst_pc(inst_pc), .inst_word(inst_word),
    .inst_ready(inst_ready),
    .flush(flush), .flush_pc(flush_pc),
    .rs1_addr(rs1_addr), .rs1_data(rs1_data),
    .rs2_addr(rs2_addr), .rs2_data(rs2_data),
    .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data),
    .ar_valid(ex_arvalid), .ar_addr(ex_araddr), .ar_ready(ex_arready),
    .r_valid(ex_rvalid), .r_data(ex_rdata),
    .mem_awvalid(mem_awvalid), .mem_awaddr(mem_awaddr), .mem_wdata(mem_wdata),
    .mem_awready(mem_awready), .mem_bvalid(mem_bvalid)
  );

  reg_file rf0 (
    .clock(clock), .rst_n(rst_n),
    .rs1_addr(rs1_addr), .rs1_data(rs1_data),
    .rs2_addr(rs2_addr), .rs2_data(rs2_data),
    .rd_we(rd_we), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  mem_arbiter arb0 (
    .clock(clock), .rst_n(rst_n),
    .if_arvalid(if_arvalid), .if_araddr(if_araddr), .if_arready(if_arready),
    .if_rvalid(if_rvalid), .if_rdata(if_rdata),
    .ex_arvalid(ex_arvalid), .ex_araddr(ex_araddr), .ex_arready(ex_arready),
    .ex_rvalid(ex_rvalid), .ex_rdata(ex_rdata),
    .bus_arvalid(bus_arvalid), .bus_araddr(bus_araddr), .bus_arready(bus_arready),
    .bus_rvalid(bus_rvalid), .bus_rdata(bus_rdata)
  );

  addr_xbar xbar0 (
    .clock(clock), .rst_n(rst_n),
    .bus_arvalid(bus_arvalid), .bus_araddr(bus_araddr), .bus_arready(bus_arready),
    .bus_rvalid(bus_rvalid), .bus_rdata(bus_rdata),
    .mem_arvalid(mem_arvalid), .mem_araddr(mem_araddr), .mem_arready(mem_arready),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .tmr_rd(tmr_rd), .tmr_addr(tmr_addr), .tmr_rdata(tmr_rdata)
  );

  timer_clint timer0 (
    .clock(clock), .rst_n(rst_n),
    .tmr_rd(tmr_rd), .tmr_addr(tmr_addr), .tmr_rdata(tmr_rdata)
  );

endmodule

`default_nettype wire

//--- src/timer_clint.sv
`timescale 1ns/1ps
`default_nettype none

module timer_clint (
  input  wire              clock,
  input  wire              rst_n,
  input  wire              tmr_rd,
  input  wire  [1:0]       tmr_addr,
  output core_pkg::word_t  tmr_rdata
);
  import core_pkg::*;

  logic [63:0] mtime;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtime <= 64'd0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // words 2 and 3 of the window read as zero
  always_ff @(posedge clock) begin
    if (tmr_rd) begin
      case (tmr_addr)
        2'd0:    tmr_rdata <= mtime[31:0];
        2'd1:    tmr_rdata <= mtime[63:32];
        default: tmr_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/addr_xbar.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module addr_xbar (
  input  wire                   clock,
  input  wire                   rst_n,
  input  wire                   bus_arvalid,
  input  wire  core_pkg::addr_t bus_araddr,
  output logic                  bus_arready,
  output logic                  bus_rvalid,
  output core_pkg::word_t       bus_rdata,
  output logic                  mem_arvalid,
  output core_pkg::addr_t       mem_araddr,
  input  wire                   mem_arready,
  input  wire                   mem_rvalid,
  input  wire  core_pkg::word_t mem_rdata,
  output logic                  tmr_rd,
  output logic [1:0]            tmr_addr,
  input  wire  core_pkg::word_t tmr_rdata
);
  import core_pkg::*;

  localparam addr_t TIMER_BASE = `CORE_TIMER_BASE;

  logic is_tmr;
  logic rd_tgt_tmr;

  assign is_tmr = (bus_araddr[31:4] == TIMER_BASE[31:4]);

  // the timer always accepts, memory sees only addresses outside the window
  assign mem_arvalid = bus_arvalid && !is_tmr;
  assign mem_araddr  = bus_araddr;
  assign tmr_rd      = bus_arvalid && is_tmr;
  assign tmr_addr    = bus_araddr[3:2];
  assign bus_arready = is_tmr ? 1'b1 : mem_arready;

  // set only for the one cycle in which the timer answers
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rd_tgt_tmr <= 1'b0;
    end else if (bus_arvalid && bus_arready) begin
      rd_tgt_tmr <= is_tmr;
    end else if (rd_tgt_tmr) begin
      rd_tgt_tmr <= 1'b0;
    end
  end

  assign bus_rvalid = rd_tgt_tmr ? 1'b1 : mem_rvalid;
  assign bus_rdata  = rd_tgt_tmr ? tmr_rdata : mem_rdata;

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module mem_arbiter (
  input  wire                   clock,
  input  wire                   rst_n,
  input  wire                   if_arvalid,
  input  wire  core_pkg::addr_t if_araddr,
  output logic                  if_arready,
  output logic                  if_rvalid,
  output core_pkg::word_t       if_rdata,
  input  wire                   ex_arvalid,
  input  wire  core_pkg::addr_t ex_araddr,
  output logic                  ex_arready,
  output logic                  ex_rvalid,
  output core_pkg::word_t       ex_rdata,
  output logic                  bus_arvalid,
  output core_pkg::addr_t       bus_araddr,
  input  wire                   bus_arready,
  input  wire                   bus_rvalid,
  input  wire  core_pkg::word_t bus_rdata
);
  import core_pkg::*;

  arb_state_t arb_state;

  // the owner keeps the bus until its response comes back
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      arb_state <= IDLE;
    end else begin
      case (arb_state)
        IDLE: begin
          if (ex_arvalid) begin
            arb_state <= LOAD_BUSY;
          end else if (if_arvalid) begin
            arb_state <= FETCH_BUSY;
          end
        end
        FETCH_BUSY, LOAD_BUSY: begin
          if (bus_rvalid) begin
            arb_state <= IDLE;
          end
        end
        default: arb_state <= IDLE;
      endcase
    end
  end

  assign bus_arvalid = (arb_state == FETCH_BUSY) ? if_arvalid :
                       (arb_state == LOAD_BUSY)  ? ex_arvalid : 1'b0;
  assign bus_araddr  = (arb_state == LOAD_BUSY) ? ex_araddr : if_araddr;

  assign if_arready = (arb_state == FETCH_BUSY) && bus_arready;
  assign ex_arready = (arb_state == LOAD_BUSY) && bus_arready;
  assign if_rvalid  = (arb_state == FETCH_BUSY) && bus_rvalid;
  assign ex_rvalid  = (arb_state == LOAD_BUSY) && bus_rvalid;
  assign if_rdata   = bus_rdata;
  assign ex_rdata   = bus_rdata;

  a_no_orphan_resp: assert property (@(posedge clock) disable iff (!rst_n)
    bus_rvalid |-> (arb_state != IDLE))
    else $error("read response with no owner");

  a_watchdog: assert property (@(posedge clock) disable iff (!rst_n)
    (arb_state != IDLE) |-> ##[1:`CORE_ARB_WATCHDOG] (arb_state == IDLE))
    else $error("bus owner waited too long for a response");

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                      clock,
  input  wire                      rst_n,
  input  wire  core_pkg::reg_idx_t rs1_addr,
  output core_pkg::word_t          rs1_data,
  input  wire  core_pkg::reg_idx_t rs2_addr,
  output core_pkg::word_t          rs2_data,
  input  wire                      rd_we,
  input  wire  core_pkg::reg_idx_t rd_addr,
  input  wire  core_pkg::word_t    rd_data
);
  import core_pkg::*;

  word_t regs [32];

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // x0 is never written, so it reads zero from reset on
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- execute/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  wire                      clock,
  input  wire                      rst_n,
  input  wire                      inst_valid,
  input  wire  core_pkg::addr_t    inst_pc,
  input  wire  core_pkg::word_t    inst_word,
  output logic                     inst_ready,
  output logic                     flush,
  output core_pkg::addr_t          flush_pc,
  output core_pkg::reg_idx_t       rs1_addr,
  input  wire  core_pkg::word_t    rs1_data,
  output core_pkg::reg_idx_t       rs2_addr,
  input  wire  core_pkg::word_t    rs2_data,
  output logic                     rd_we,
  output core_pkg::reg_idx_t       rd_addr,
  output core_pkg::word_t          rd_data,
  output logic                     ar_valid,
  output core_pkg::addr_t          ar_addr,
  input  wire                      ar_ready,
  input  wire                      r_valid,
  input  wire  core_pkg::word_t    r_data,
  output logic                     mem_awvalid,
  output core_pkg::addr_t          mem_awaddr,
  output core_pkg::word_t          mem_wdata,
  input  wire                      mem_awready,
  input  wire                      mem_bvalid
);
  import core_pkg::*;

  ex_state_t ex_state;
  logic      ex_valid;
  word_t     ex_inst;
  addr_t     ex_pc;
  opcode_t   op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_j;
  logic      is_lw;
  logic      is_sw;

  // new instructions only enter when nothing is executing or outstanding
  assign inst_ready = !ex_valid && (ex_state == EX_IDLE);

  assign op     = opcode_t'(ex_inst[6:0]);
  assign funct3 = ex_inst[14:12];
  assign funct7 = ex_inst[31:25];

  assign imm_i = {{20{ex_inst[31]}}, ex_inst[31:20]};
  assign imm_s = {{20{ex_inst[31]}}, ex_inst[31:25], ex_inst[11:7]};
  assign imm_b = {{20{ex_inst[31]}}, ex_inst[7], ex_inst[30:25], ex_inst[11:8], 1'b0};
  assign imm_j = {{12{ex_inst[31]}}, ex_inst[19:12], ex_inst[20], ex_inst[30:21], 1'b0};

  assign rs1_addr = ex_inst[19:15];
  assign rs2_addr = ex_inst[24:20];
  assign rd_addr  = ex_inst[11:7];

  assign is_lw = ex_valid && (op == LOAD) && (funct3 == 3'b010);
  assign is_sw = ex_valid && (op == STORE) && (funct3 == 3'b010);

  always_comb begin
    rd_we    = 1'b0;
    rd_data  = r_data;
    flush    = 1'b0;
    flush_pc = ex_pc + imm_b;
    if (ex_valid) begin
      case (op)
        OP_IMM: begin
          rd_we   = (funct3 == 3'b000);
          rd_data = rs1_data + imm_i;
        end
        OP: begin
          rd_we   = (funct3 == 3'b000) && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
          rd_data = funct7[5] ? rs1_data - rs2_data : rs1_data + rs2_data;
        end
        LUI: begin
          rd_we   = 1'b1;
          rd_data = {ex_inst[31:12], 12'b0};
        end
        BRANCH: begin
          if (funct3 == 3'b000) begin
            flush = (rs1_data == rs2_data);
          end else if (funct3 == 3'b001) begin
            flush = (rs1_data != rs2_data);
          end
        end
        JAL: begin
          rd_we    = 1'b1;
          rd_data  = ex_pc + 32'd4;
          flush    = 1'b1;
          flush_pc = ex_pc + imm_j;
        end
        default: begin
          rd_we = 1'b0;
        end
      endcase
    end else if (ex_state == EX_LOAD) begin
      rd_we = r_valid;
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid    <= 1'b0;
      ex_state    <= EX_IDLE;
      ar_valid    <= 1'b0;
      mem_awvalid <= 1'b0;
    end else begin
      ex_valid <= inst_valid && inst_ready;
      case (ex_state)
        EX_IDLE: begin
          if (is_lw) begin
            ex_state <= EX_LOAD;
            ar_valid <= 1'b1;
          end else if (is_sw) begin
            ex_state    <= EX_STORE;
            mem_awvalid <= 1'b1;
          end
        end
        EX_LOAD: begin
          if (ar_valid && ar_ready) begin
            ar_valid <= 1'b0;
          end
          if (r_valid) begin
            ex_state <= EX_IDLE;
          end
        end
        EX_STORE: begin
          if (mem_awvalid && mem_awready) begin
            mem_awvalid <= 1'b0;
          end
          if (mem_bvalid) begin
            ex_state <= EX_IDLE;
          end
        end
        default: ex_state <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (inst_valid && inst_ready) begin
      ex_inst <= inst_word;
      ex_pc   <= inst_pc;
    end
    if (is_lw) begin
      ar_addr <= rs1_data + imm_i;
    end
    if (is_sw) begin
      mem_awaddr <= rs1_data + imm_s;
      mem_wdata  <= rs2_data;
    end
  end

  // a redirect during a load would let fetch race ahead of the writeback
  a_no_flush_in_load: assert property (@(posedge clock) disable iff (!rst_n)
    flush |-> (ex_state != EX_LOAD))
    else $error("flush raised while a load is outstanding");

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module fetch_unit (
  input  wire                   clock,
  input  wire                   rst_n,
  input  wire                   flush,
  input  wire  core_pkg::addr_t flush_pc,
  output logic                  ar_valid,
  output core_pkg::addr_t       ar_addr,
  input  wire                   ar_ready,
  input  wire                   r_valid,
  input  wire  core_pkg::word_t r_data,
  output logic                  inst_valid,
  output core_pkg::addr_t       inst_pc,
  output core_pkg::word_t       inst_word,
  input  wire                   inst_ready
);
  import core_pkg::*;

  addr_t pc;
  addr_t fetch_addr;
  word_t buf_word;
  addr_t buf_pc;
  logic  buf_valid;
  logic  outstanding;
  logic  stale;
  logic  inflight;
  logic  issue;

  assign inflight   = ar_valid | outstanding;
  assign fetch_addr = flush ? flush_pc : pc;
  // a new read starts as soon as the buffer is free or being drained
  assign issue = !inflight && (!buf_valid || (inst_valid && inst_ready) || flush);

  assign inst_valid = buf_valid;
  assign inst_pc    = buf_pc;
  assign inst_word  = buf_word;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= `CORE_RESET_PC;
      ar_valid    <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
      buf_valid   <= 1'b0;
    end else begin
      if (issue) begin
        ar_valid <= 1'b1;
      end else if (ar_valid && ar_ready) begin
        ar_valid    <= 1'b0;
        outstanding <= 1'b1;
      end
      if (r_valid) begin
        outstanding <= 1'b0;
      end

      // a stale read must not move the pc away from the redirect target
      if (flush) begin
        pc <= flush_pc;
      end else if (ar_valid && ar_ready && !stale) begin
        pc <= ar_addr + 32'd4;
      end

      // the response of a read issued before the redirect is dropped
      if (r_valid) begin
        stale <= 1'b0;
      end else if (flush && inflight) begin
        stale <= 1'b1;
      end

      if (flush) begin
        buf_valid <= 1'b0;
      end else if (r_valid && !stale) begin
        buf_valid <= 1'b1;
      end else if (inst_valid && inst_ready) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      ar_addr <= fetch_addr;
    end
    if (r_valid && !stale && !flush) begin
      buf_pc   <= ar_addr;
      buf_word <= r_data;
    end
  end

  a_fetch_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    ar_valid |-> (ar_addr[1:0] == 2'b00))
    else $error("fetch address not word aligned");

endmodule

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  // owner of the shared read bus
  typedef enum logic [1:0] {
    IDLE,
    FETCH_BUSY,
    LOAD_BUSY
  } arb_state_t;

  // memory operation still outstanding in the execute unit
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_LOAD,
    EX_STORE
  } ex_state_t;

endpackage

`default_nettype wire

//--- common/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first instruction address after reset
`define CORE_RESET_PC 32'h0000_0000

// 16-byte timer window, word 0 is mtime low and word 1 is mtime high
`define CORE_TIMER_BASE 32'h0200_0000

// upper bound in cycles for one arbitrated read to complete
`define CORE_ARB_WATCHDOG 64

`endif
